// ==== verilog/fm_pkg.sv ====
package fm_pkg;

	// slot address is {op, ch}
	parameter int SLOT_W = 5;
	parameter int NUM_SLOTS = 24;
	parameter int NUM_CH = 6;

	// tl dt1 mul ks ar am d1r d2r d1l rr ssg_en ssg_eg
	parameter int OPREG_W = 44;
	// latch(block, fnum hi) block fnum fb alg ams pms, rl travels on its own
	parameter int CHREG_W = 31;

	typedef enum logic [3:0] {
		FLD_NONE, FLD_KEYON, FLD_DT1_MUL, FLD_TL, FLD_KS_AR, FLD_AM_D1R, FLD_D2R,
		FLD_D1L_RR, FLD_SSG, FLD_FNUM_LO, FLD_BLOCK_FNHI, FLD_FB_ALG, FLD_LR_AMS_PMS
	} fm_field_e;

	typedef enum logic [1:0] {
		BUS_IDLE, BUS_WAIT, BUS_ACK
	} fm_bus_state_e;

	// modulator input selection of one operator
	typedef enum logic [2:0] {
		SRC_NONE, SRC_FB, SRC_PREV1, SRC_PREV2, SRC_PREVPREV1, SRC_PREV1_PREV2
	} fm_mod_src_e;

	// dense 0..23 index of a slot, channels 4..6 fold onto 3..5
	function automatic logic [4:0] slot_index(input logic [SLOT_W-1:0] slot);
		logic [2:0] ch_pos;
		ch_pos = slot[2] ? slot[2:0] - 3'd1 : slot[2:0];
		return {3'd0, slot[4:3]} * 5'd6 + {2'd0, ch_pos};
	endfunction

endpackage

// ==== verilog/fm_slot_seq.sv ====
`timescale 1ns/1ps

module fm_slot_seq (
	input  logic clk,
	input  logic rst,
	input  logic clk_en,
	output logic [fm_pkg::SLOT_W-1:0] cur_slot,
	output logic [fm_pkg::SLOT_W-1:0] next_slot,
	output logic zero,
	output logic pos_s1,
	output logic pos_s2,
	output logic pos_s3,
	output logic pos_s4
);

	logic [1:0] cur_op;
	logic [1:0] next_op;
	logic [2:0] cur_ch;
	logic [2:0] next_ch;

	// channels run 0 1 2 4 5 6, operator steps after channel 6
	always_comb begin
		next_op = (cur_ch == 3'd6) ? cur_op + 2'd1 : cur_op;
		next_ch = (cur_ch[1:0] == 2'd2) ? cur_ch + 3'd2 : cur_ch + 3'd1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_op <= 2'd0;
			cur_ch <= 3'd0;
			zero <= 1'b1;
		end else if (clk_en) begin
			cur_op <= next_op;
			cur_ch <= next_ch;
			zero <= ({next_op, next_ch} == '0);
		end
	end

	assign cur_slot = {cur_op, cur_ch};
	assign next_slot = {next_op, next_ch};

	// operator index 0 1 2 3 is S1 S3 S2 S4
	assign pos_s1 = (cur_op == 2'd0);
	assign pos_s3 = (cur_op == 2'd1);
	assign pos_s2 = (cur_op == 2'd2);
	assign pos_s4 = (cur_op == 2'd3);

endmodule

// ==== verilog/fm_op_ram.sv ====
`timescale 1ns/1ps

module fm_op_ram #(
	parameter int OPREG_W = 44
) (
	input  logic clk,
	input  logic [fm_pkg::SLOT_W-1:0] wr_addr,
	input  logic [fm_pkg::SLOT_W-1:0] rd_addr,
	input  logic [OPREG_W-1:0] data,
	output logic [OPREG_W-1:0] q
);

	// one word per operator slot, power-up contents are zero
	logic [OPREG_W-1:0] mem [fm_pkg::NUM_SLOTS] = '{default: '0};
	logic [OPREG_W-1:0] q_r = '0;

	always_ff @(posedge clk) begin
		mem[fm_pkg::slot_index(wr_addr)] <= data;
		q_r <= mem[fm_pkg::slot_index(rd_addr)];
	end

	assign q = q_r;

endmodule

// ==== verilog/fm_ch_shift.sv ====
`timescale 1ns/1ps

module fm_ch_shift #(
	parameter int width = 1,
	parameter int stages = 2
) (
	input  logic clk,
	input  logic clk_en,
	input  logic [width-1:0] din,
	output logic [width-1:0] drop
);

	logic [width-1:0] bank [stages] = '{default: '0};

	// one stage per slot, so a word comes back when its channel is current
	always_ff @(posedge clk) begin
		if (clk_en) begin
			bank[0] <= din;
			for (int i = 1; i < stages; i++)
				bank[i] <= bank[i-1];
		end
	end

	assign drop = bank[stages-1];

endmodule

// ==== verilog/fm_keyon.sv ====
`timescale 1ns/1ps

module fm_keyon (
	input  logic clk,
	input  logic rst,
	input  logic clk_en,
	input  logic [fm_pkg::SLOT_W-1:0] cur_slot,
	input  logic [3:0] kon_mask,
	input  logic [2:0] kon_ch,
	input  logic kon_active,
	output logic keyon
);

	logic [fm_pkg::NUM_SLOTS-1:0] kon_bits;
	logic [4:0] idx;
	logic mask_bit;

	assign idx = fm_pkg::slot_index(cur_slot);

	// mask bits are S1 S2 S3 S4 while op index runs S1 S3 S2 S4
	always_comb begin
		case (cur_slot[4:3])
			2'd0: mask_bit = kon_mask[0];
			2'd1: mask_bit = kon_mask[2];
			2'd2: mask_bit = kon_mask[1];
			default: mask_bit = kon_mask[3];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			kon_bits <= '0;
		else if (clk_en && kon_active && cur_slot[2:0] == kon_ch)
			kon_bits[idx] <= mask_bit;
	end

	assign keyon = kon_bits[idx];

endmodule

// ==== verilog/fm_mod_route.sv ====
`timescale 1ns/1ps

module fm_mod_route (
	input  logic [2:0] alg,
	input  logic pos_s1,
	input  logic pos_s2,
	input  logic pos_s3,
	input  logic pos_s4,
	output fm_pkg::fm_mod_src_e mod_src,
	output logic carrier
);

	// connection table of the eight algorithms
	always_comb begin
		mod_src = fm_pkg::SRC_NONE;
		carrier = 1'b0;
		if (pos_s1) begin
			mod_src = fm_pkg::SRC_FB;
			carrier = (alg == 3'd7);
		end else if (pos_s3) begin
			mod_src = (alg <= 3'd3) ? fm_pkg::SRC_PREV1 : fm_pkg::SRC_NONE;
			carrier = (alg >= 3'd5);
		end else if (pos_s2) begin
			case (alg)
				3'd1: mod_src = fm_pkg::SRC_PREV1_PREV2;
				3'd5: mod_src = fm_pkg::SRC_PREVPREV1;
				3'd6, 3'd7: mod_src = fm_pkg::SRC_NONE;
				default: mod_src = fm_pkg::SRC_PREV1;
			endcase
			carrier = (alg >= 3'd4);
		end else if (pos_s4) begin
			case (alg)
				3'd2, 3'd3: mod_src = fm_pkg::SRC_PREV1_PREV2;
				3'd7: mod_src = fm_pkg::SRC_NONE;
				default: mod_src = fm_pkg::SRC_PREV1;
			endcase
			// S4 is the output in every algorithm
			carrier = 1'b1;
		end
	end

endmodule

// ==== verilog/fm_regs.sv ====
`timescale 1ns/1ps

module fm_regs #(
	parameter int OPREG_W = 44,
	parameter int CHREG_W = 31
) (
	input  logic clk,
	input  logic rst,
	input  logic clk_en,
	input  logic req,
	input  fm_pkg::fm_field_e field,
	input  logic [2:0] wr_ch,
	input  logic [1:0] wr_op,
	input  logic [7:0] wr_data,
	output logic done,
	output logic busy,
	output logic [6:0] tl,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic am_en,
	output logic [4:0] d1r,
	output logic [4:0] d2r,
	output logic [3:0] d1l,
	output logic [3:0] rr,
	output logic ssg_en,
	output logic [2:0] ssg_eg,
	output logic [10:0] fnum,
	output logic [2:0] block,
	output logic [2:0] fb,
	output logic [2:0] alg,
	output logic [1:0] rl,
	output logic [1:0] ams,
	output logic [2:0] pms,
	output logic zero,
	output logic keyon,
	output fm_pkg::fm_mod_src_e mod_src,
	output logic carrier
);

	logic [fm_pkg::SLOT_W-1:0] cur_slot;
	logic [fm_pkg::SLOT_W-1:0] next_slot;
	logic [fm_pkg::SLOT_W-1:0] rd_slot;
	logic pos_s1, pos_s2, pos_s3, pos_s4;
	logic [OPREG_W-1:0] op_q;
	logic [OPREG_W-1:0] op_d;
	logic [CHREG_W-1:0] ch_q;
	logic [CHREG_W-1:0] ch_d;
	logic [2:0] lat_blk;
	logic [2:0] lat_fnh;
	logic [1:0] rl_d;
	logic [1:0] rl_inv;
	logic op_match, ch_match, hit;
	logic kon_active, kon_last;
	logic [4:0] kon_cnt;

	fm_slot_seq u_seq (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.cur_slot(cur_slot), .next_slot(next_slot), .zero(zero),
		.pos_s1(pos_s1), .pos_s2(pos_s2), .pos_s3(pos_s3), .pos_s4(pos_s4)
	);

	assign op_match = clk_en && req && cur_slot == {wr_op, wr_ch};
	assign ch_match = clk_en && req && cur_slot[2:0] == wr_ch;

	// a pending write lands on its own slot or its own channel
	always_comb begin
		case (field)
			fm_pkg::FLD_NONE, fm_pkg::FLD_KEYON: hit = 1'b0;
			fm_pkg::FLD_FNUM_LO, fm_pkg::FLD_BLOCK_FNHI,
			fm_pkg::FLD_FB_ALG, fm_pkg::FLD_LR_AMS_PMS: hit = ch_match;
			default: hit = op_match;
		endcase
	end

	// key-on stays active for a whole frame so all four operators see it
	assign kon_active = req && field == fm_pkg::FLD_KEYON;
	assign kon_last = kon_active && clk_en && kon_cnt == 5'(fm_pkg::NUM_SLOTS - 1);
	assign done = hit || kon_last;

	always_ff @(posedge clk) begin
		if (rst || !kon_active)
			kon_cnt <= '0;
		else if (clk_en)
			kon_cnt <= kon_cnt + 5'd1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else
			busy <= req && !done;
	end

	// hold the current slot while the sequencer is stalled
	assign rd_slot = clk_en ? next_slot : cur_slot;

	fm_op_ram #(.OPREG_W(OPREG_W)) u_op_ram (
		.clk(clk), .wr_addr(cur_slot), .rd_addr(rd_slot), .data(op_d), .q(op_q)
	);

	assign {tl, dt1, mul, ks, ar, am_en, d1r, d2r, d1l, rr, ssg_en, ssg_eg} = op_q;

	assign op_d = {
		(hit && field == fm_pkg::FLD_TL) ? wr_data[6:0] : tl,
		(hit && field == fm_pkg::FLD_DT1_MUL) ? wr_data[6:4] : dt1,
		(hit && field == fm_pkg::FLD_DT1_MUL) ? wr_data[3:0] : mul,
		(hit && field == fm_pkg::FLD_KS_AR) ? wr_data[7:6] : ks,
		(hit && field == fm_pkg::FLD_KS_AR) ? wr_data[4:0] : ar,
		(hit && field == fm_pkg::FLD_AM_D1R) ? wr_data[7] : am_en,
		(hit && field == fm_pkg::FLD_AM_D1R) ? wr_data[4:0] : d1r,
		(hit && field == fm_pkg::FLD_D2R) ? wr_data[4:0] : d2r,
		(hit && field == fm_pkg::FLD_D1L_RR) ? wr_data[7:4] : d1l,
		(hit && field == fm_pkg::FLD_D1L_RR) ? wr_data[3:0] : rr,
		(hit && field == fm_pkg::FLD_SSG) ? wr_data[3:0] : {ssg_en, ssg_eg}
	};

	fm_ch_shift #(.width(CHREG_W), .stages(fm_pkg::NUM_CH)) u_ch_shift (
		.clk(clk), .clk_en(clk_en), .din(ch_d), .drop(ch_q)
	);

	assign {lat_blk, lat_fnh, block, fnum, fb, alg, ams, pms} = ch_q;

	// block and fnum high wait in the latch until the fnum low byte arrives
	assign ch_d = {
		(hit && field == fm_pkg::FLD_BLOCK_FNHI) ? wr_data[5:0] : {lat_blk, lat_fnh},
		(hit && field == fm_pkg::FLD_FNUM_LO) ? {lat_blk, lat_fnh, wr_data} : {block, fnum},
		(hit && field == fm_pkg::FLD_FB_ALG) ? wr_data[5:0] : {fb, alg},
		(hit && field == fm_pkg::FLD_LR_AMS_PMS) ? {wr_data[5:4], wr_data[2:0]} : {ams, pms}
	};

	// rl is stored inverted so the cleared shift register reads both speakers on
	assign rl_d = (hit && field == fm_pkg::FLD_LR_AMS_PMS) ? wr_data[7:6] : rl;
	assign rl = ~rl_inv;

	fm_ch_shift #(.width(2), .stages(fm_pkg::NUM_CH)) u_rl_shift (
		.clk(clk), .clk_en(clk_en), .din(~rl_d), .drop(rl_inv)
	);

	fm_keyon u_keyon (
		.clk(clk), .rst(rst), .clk_en(clk_en), .cur_slot(cur_slot),
		.kon_mask(wr_data[7:4]), .kon_ch(wr_data[2:0]), .kon_active(kon_active),
		.keyon(keyon)
	);

	fm_mod_route u_route (
		.alg(alg), .pos_s1(pos_s1), .pos_s2(pos_s2), .pos_s3(pos_s3), .pos_s4(pos_s4),
		.mod_src(mod_src), .carrier(carrier)
	);

endmodule

// ==== verilog/fm_bus_if.sv ====
`timescale 1ns/1ps

module fm_bus_if (
	input  logic clk,
	input  logic rst,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [8:0] adr,
	input  logic [7:0] dat_w,
	output logic [7:0] dat_r,
	output logic ack,
	output logic req,
	output fm_pkg::fm_field_e field,
	output logic [2:0] wr_ch,
	output logic [1:0] wr_op,
	output logic [7:0] wr_data,
	input  logic done,
	input  logic busy
);

	fm_pkg::fm_bus_state_e state;
	fm_pkg::fm_field_e dec_field;

	// register map decode, adr[8] picks channels 4..6
	always_comb begin
		dec_field = fm_pkg::FLD_NONE;
		if (adr[7:0] == 8'h28) begin
			dec_field = fm_pkg::FLD_KEYON;
		end else if (adr[1:0] != 2'd3) begin
			case (adr[7:4])
				4'h3: dec_field = fm_pkg::FLD_DT1_MUL;
				4'h4: dec_field = fm_pkg::FLD_TL;
				4'h5: dec_field = fm_pkg::FLD_KS_AR;
				4'h6: dec_field = fm_pkg::FLD_AM_D1R;
				4'h7: dec_field = fm_pkg::FLD_D2R;
				4'h8: dec_field = fm_pkg::FLD_D1L_RR;
				4'h9: dec_field = fm_pkg::FLD_SSG;
				4'hA: begin
					if (!adr[3])
						dec_field = adr[2] ? fm_pkg::FLD_BLOCK_FNHI : fm_pkg::FLD_FNUM_LO;
				end
				4'hB: begin
					if (!adr[3])
						dec_field = adr[2] ? fm_pkg::FLD_LR_AMS_PMS : fm_pkg::FLD_FB_ALG;
				end
				default: dec_field = fm_pkg::FLD_NONE;
			endcase
		end
	end

	// reads and unmapped writes pass through WAIT without a request
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fm_pkg::BUS_IDLE;
			req <= 1'b0;
			field <= fm_pkg::FLD_NONE;
		end else begin
			case (state)
				fm_pkg::BUS_IDLE: begin
					if (cyc && stb) begin
						state <= fm_pkg::BUS_WAIT;
						req <= we && dec_field != fm_pkg::FLD_NONE;
						field <= dec_field;
					end
				end
				fm_pkg::BUS_WAIT: begin
					if (!req || done) begin
						state <= fm_pkg::BUS_ACK;
						req <= 1'b0;
					end
				end
				default: state <= fm_pkg::BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fm_pkg::BUS_IDLE && cyc && stb) begin
			wr_ch <= {adr[8], adr[1:0]};
			wr_op <= adr[3:2];
			wr_data <= dat_w;
		end
	end

	assign ack = (state == fm_pkg::BUS_ACK);
	assign dat_r = {busy, 7'd0};

endmodule

// ==== verilog/fm_core_top.sv ====
`timescale 1ns/1ps

module fm_core_top #(
	parameter int OPREG_W = fm_pkg::OPREG_W,
	parameter int CHREG_W = fm_pkg::CHREG_W
) (
	input  logic clk,
	input  logic rst,
	input  logic clk_en,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  logic [8:0] adr,
	input  logic [7:0] dat_w,
	output logic [7:0] dat_r,
	output logic ack,
	output logic [6:0] tl,
	output logic [2:0] dt1,
	output logic [3:0] mul,
	output logic [1:0] ks,
	output logic [4:0] ar,
	output logic am_en,
	output logic [4:0] d1r,
	output logic [4:0] d2r,
	output logic [3:0] d1l,
	output logic [3:0] rr,
	output logic ssg_en,
	output logic [2:0] ssg_eg,
	output logic [10:0] fnum,
	output logic [2:0] block,
	output logic [2:0] fb,
	output logic [2:0] alg,
	output logic [1:0] rl,
	output logic [1:0] ams,
	output logic [2:0] pms,
	output logic zero,
	output logic keyon,
	output fm_pkg::fm_mod_src_e mod_src,
	output logic carrier
);

	logic req, done, busy;
	fm_pkg::fm_field_e field;
	logic [2:0] wr_ch;
	logic [1:0] wr_op;
	logic [7:0] wr_data;

	fm_bus_if u_bus (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.req(req), .field(field), .wr_ch(wr_ch), .wr_op(wr_op), .wr_data(wr_data),
		.done(done), .busy(busy)
	);

	fm_regs #(.OPREG_W(OPREG_W), .CHREG_W(CHREG_W)) u_regs (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.req(req), .field(field), .wr_ch(wr_ch), .wr_op(wr_op), .wr_data(wr_data),
		.done(done), .busy(busy),
		.tl(tl), .dt1(dt1), .mul(mul), .ks(ks), .ar(ar), .am_en(am_en),
		.d1r(d1r), .d2r(d2r), .d1l(d1l), .rr(rr), .ssg_en(ssg_en), .ssg_eg(ssg_eg),
		.fnum(fnum), .block(block), .fb(fb), .alg(alg), .rl(rl), .ams(ams), .pms(pms),
		.zero(zero), .keyon(keyon), .mod_src(mod_src), .carrier(carrier)
	);

endmodule

// ==== testbench/fm_core_assertions.sv ====
`timescale 1ns/1ps

module fm_core_assertions (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic zero,
	input logic busy
);

	// number of failed assertions so far
	int unsigned fail_cnt = 0;

	// ack is a single cycle pulse inside an active bus cycle
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else begin
			$error("ack held longer than one cycle");
			fail_cnt++;
		end
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
		else begin
			$error("ack outside cyc and stb");
			fail_cnt++;
		end

	// with clk_en held high a frame is 24 clocks
	zero_period: assert property (@(posedge clk) disable iff (rst)
		zero |=> !zero [*23] ##1 zero)
		else begin
			$error("zero marker not every 24 slots");
			fail_cnt++;
		end

	// busy only while a write waits for its slot, so never on an idle bus
	busy_idle_low: assert property (@(posedge clk) disable iff (rst) !cyc |-> !busy)
		else begin
			$error("busy high while the bus is idle");
			fail_cnt++;
		end

endmodule

bind fm_core_top fm_core_assertions u_checks (
	.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .zero(zero), .busy(dat_r[7])
);

// ==== testbench/fm_core_tb.sv ====
`timescale 1ns/1ps

module fm_core_tb;

	typedef struct {
		string name;
		logic bank;
		logic [7:0] rnum;
		logic [7:0] data;
		bit rnd;
		bit mapped;
	} entry_t;

	logic clk = 1'b0;
	logic rst, clk_en, cyc, stb, we;
	logic [8:0] adr;
	logic [7:0] dat_w, dat_r, rd_data;
	logic ack, am_en, ssg_en, zero, keyon, carrier;
	logic [6:0] tl;
	logic [2:0] dt1, ssg_eg, block, fb, alg, pms;
	logic [3:0] mul, d1l, rr;
	logic [1:0] ks, rl, ams;
	logic [4:0] ar, d1r, d2r;
	logic [10:0] fnum;
	fm_pkg::fm_mod_src_e mod_src;

	// expected raw register bytes per slot and per channel position
	logic [7:0] op_reg [7][24];
	logic [7:0] fn_lo [6], fn_hi [6], fn_latch [6], fb_alg [6], lr_reg [6];
	logic kon [24];
	logic [31:0] lfsr = 32'had99;
	entry_t stim [$];

	fm_core_top UUT (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	function automatic int ch_pos(logic [2:0] ch);
		return (ch < 4) ? int'(ch) : int'(ch) - 1;
	endfunction

	// connection table with op index 0..3 as S1 S3 S2 S4
	function automatic fm_pkg::fm_mod_src_e route_of(int op, logic [2:0] a);
		case (op)
			0: return fm_pkg::SRC_FB;
			1: return (a <= 3) ? fm_pkg::SRC_PREV1 : fm_pkg::SRC_NONE;
			2: begin
				if (a == 1) return fm_pkg::SRC_PREV1_PREV2;
				if (a == 5) return fm_pkg::SRC_PREVPREV1;
				return (a >= 6) ? fm_pkg::SRC_NONE : fm_pkg::SRC_PREV1;
			end
			default: begin
				if (a == 7) return fm_pkg::SRC_NONE;
				return (a == 2 || a == 3) ? fm_pkg::SRC_PREV1_PREV2 : fm_pkg::SRC_PREV1;
			end
		endcase
	endfunction

	function automatic logic is_carrier(int op, logic [2:0] a);
		return (op == 3) || (op == 2 && a >= 4) || (op == 1 && a >= 5) || (op == 0 && a == 7);
	endfunction

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_field(string name, logic [7:0] exp, logic [7:0] act);
		if (exp !== act)
			fail_now($sformatf("Error: %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic check_src(string name, fm_pkg::fm_mod_src_e exp, fm_pkg::fm_mod_src_e act);
		if (exp !== act)
			fail_now($sformatf("Error: %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act)
			fail_now($sformatf("Error: %s expected %0b actual %0b", name, exp, act));
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ack && n < 40);
		if (!ack)
			fail_now("no ack from the bus within 40 cycles");
		rd_data = dat_r;
	endtask

	task automatic wait_zero();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!zero && n < 30);
		if (!zero)
			fail_now("frame marker zero missing for 30 cycles");
	endtask

	task automatic bus_cycle(logic bank, logic [7:0] rnum, logic [7:0] d, logic wr);
		@(posedge clk);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = {bank, rnum};
		dat_w = d;
		wait_ack();
		@(posedge clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic model_update(entry_t e, logic [7:0] d);
		int c;
		int kc;
		c = ch_pos({e.bank, e.rnum[1:0]});
		kc = ch_pos(d[2:0]);
		if (e.rnum == 8'h28) begin
			// mask bits 4..7 are S1 S2 S3 S4
			kon[kc] = d[4];
			kon[6 + kc] = d[6];
			kon[12 + kc] = d[5];
			kon[18 + kc] = d[7];
		end else if (e.rnum >= 8'h30 && e.rnum < 8'hA0) begin
			op_reg[e.rnum[7:4] - 3][e.rnum[3:2] * 6 + c] = d;
		end else begin
			case (e.rnum[7:2])
				6'h28: begin
					fn_lo[c] = d;
					fn_hi[c] = fn_latch[c];
				end
				6'h29: fn_latch[c] = d;
				6'h2C: fb_alg[c] = d;
				6'h2D: lr_reg[c] = d;
				default: ;
			endcase
		end
	endtask

	// let pending values reach the ports before checking one whole frame
	task automatic scan_frame(string name);
		string s;
		int c;
		int op;
		logic [7:0] r [7];
		wait_zero();
		wait_zero();
		for (int k = 0; k < 24; k++) begin
			if (k > 0)
				@(negedge clk);
			s = $sformatf("%s slot %0d", name, k);
			op = k / 6;
			c = k % 6;
			for (int g = 0; g < 7; g++)
				r[g] = op_reg[g][k];
			check_bit({s, " zero"}, k == 0, zero);
			check_field({s, " dt1"}, r[0][6:4], dt1);
			check_field({s, " mul"}, r[0][3:0], mul);
			check_field({s, " tl"}, r[1][6:0], tl);
			check_field({s, " ks"}, r[2][7:6], ks);
			check_field({s, " ar"}, r[2][4:0], ar);
			check_bit({s, " am"}, r[3][7], am_en);
			check_field({s, " d1r"}, r[3][4:0], d1r);
			check_field({s, " d2r"}, r[4][4:0], d2r);
			check_field({s, " d1l"}, r[5][7:4], d1l);
			check_field({s, " rr"}, r[5][3:0], rr);
			check_bit({s, " ssg_en"}, r[6][3], ssg_en);
			check_field({s, " ssg_eg"}, r[6][2:0], ssg_eg);
			check_field({s, " fnum lo"}, fn_lo[c], fnum[7:0]);
			check_field({s, " fnum hi"}, fn_hi[c][2:0], fnum[10:8]);
			check_field({s, " block"}, fn_hi[c][5:3], block);
			check_field({s, " fb"}, fb_alg[c][5:3], fb);
			check_field({s, " alg"}, fb_alg[c][2:0], alg);
			check_field({s, " rl"}, lr_reg[c][7:6], rl);
			check_field({s, " ams"}, lr_reg[c][5:4], ams);
			check_field({s, " pms"}, lr_reg[c][2:0], pms);
			check_bit({s, " keyon"}, kon[k], keyon);
			check_src({s, " mod_src"}, route_of(op, fb_alg[c][2:0]), mod_src);
			check_bit({s, " carrier"}, is_carrier(op, fb_alg[c][2:0]), carrier);
		end
	endtask

	task automatic add(string n, logic b, logic [7:0] rn, logic [7:0] d, bit rnd, bit m);
		entry_t e;
		e = '{n, b, rn, d, rnd, m};
		stim.push_back(e);
	endtask

	initial begin
		logic [7:0] d;
		rst = 1'b1;
		clk_en = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		for (int k = 0; k < 24; k++) begin
			kon[k] = 1'b0;
			for (int g = 0; g < 7; g++)
				op_reg[g][k] = '0;
		end
		for (int c = 0; c < 6; c++) begin
			fn_lo[c] = '0;
			fn_hi[c] = '0;
			fn_latch[c] = '0;
			fb_alg[c] = '0;
			lr_reg[c] = 8'hC0;
		end
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		scan_frame("reset");

		// operator groups in both banks
		add("dt1_mul c0 op0", 0, 8'h30, 0, 1, 1);
		add("tl c1 op1", 0, 8'h45, 0, 1, 1);
		add("ks_ar c2 op2", 0, 8'h5A, 0, 1, 1);
		add("am_d1r c4 op3", 1, 8'h6C, 0, 1, 1);
		add("d2r c5 op0", 1, 8'h71, 0, 1, 1);
		add("d1l_rr c6 op1", 1, 8'h86, 0, 1, 1);
		add("ssg c0 op3", 0, 8'h9C, 0, 1, 1);
		add("tl c6 op3", 1, 8'h4E, 0, 1, 1);
		add("dt1_mul c5 op2", 1, 8'h39, 0, 1, 1);
		// frequency latch
		add("fnhi alone c1", 0, 8'hA5, 8'h2D, 0, 1);
		add("fnlo c1", 0, 8'hA1, 8'h9B, 0, 1);
		add("fnhi c6", 1, 8'hA6, 0, 1, 1);
		add("fnlo c6", 1, 8'hA2, 0, 1, 1);
		for (int a = 0; a < 8; a++)
			add($sformatf("alg %0d c0", a), 0, 8'hB0, 8'(8'h28 | a), 0, 1);
		add("fb_alg c4", 1, 8'hB0, 0, 1, 1);
		add("lr c2", 0, 8'hB6, 8'h75, 0, 1);
		add("lr c5", 1, 8'hB5, 0, 1, 1);
		add("keyon c1 all", 0, 8'h28, 8'hF1, 0, 1);
		add("keyon c5 s1 s3", 1, 8'h28, 8'h55, 0, 1);
		add("keyon c1 off", 0, 8'h28, 8'h01, 0, 1);
		add("unmapped ch3", 0, 8'h33, 8'hFF, 0, 0);
		add("unmapped 0x20", 1, 8'h20, 8'hFF, 0, 0);
		add("unmapped A3", 0, 8'hA3, 8'hFF, 0, 0);
		add("unmapped A8", 0, 8'hA8, 8'hFF, 0, 0);
		add("unmapped B8", 1, 8'hB8, 8'hFF, 0, 0);

		foreach (stim[i]) begin
			d = stim[i].rnd ? rand_byte() : stim[i].data;
			bus_cycle(stim[i].bank, stim[i].rnum, d, 1'b1);
			if (stim[i].mapped)
				model_update(stim[i], d);
			scan_frame(stim[i].name);
		end

		bus_cycle(1'b0, 8'h30, 8'h00, 1'b0);
		check_field("read busy", 8'h00, rd_data);
		bus_cycle(1'b1, 8'hB4, 8'h00, 1'b0);
		check_field("read busy bank 1", 8'h00, rd_data);
		scan_frame("after reads");

		if (UUT.u_checks.fail_cnt != 0)
			fail_now("a bound assertion on the bus or the sequencer failed");
		else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// ==== files.f ====
verilog/fm_pkg.sv
verilog/fm_slot_seq.sv
verilog/fm_op_ram.sv
verilog/fm_ch_shift.sv
verilog/fm_keyon.sv
verilog/fm_mod_route.sv
verilog/fm_regs.sv
verilog/fm_bus_if.sv
verilog/fm_core_top.sv
testbench/fm_core_assertions.sv
testbench/fm_core_tb.sv
